/* buf_config.svh */
`ifndef BUF_CONFIG_SVH
`define BUF_CONFIG_SVH

// Data widths on the write and read side
`define BUF_WORD_W 32
`define BUF_BYTE_W 8
`define BUF_LANES 4

// Storage depth, 16 words of 4 bytes
`define BUF_W_ADDR_W 4
`define BUF_R_ADDR_W 6
`define BUF_DEPTH_BYTES 64
`define BUF_LEVEL_W 7

// Register map
`define BUF_REG_ADDR_W 2
`define BUF_REG_DATA_W 32
`define BUF_REG_CTRL 2'd0
`define BUF_REG_THRESH 2'd1
`define BUF_REG_STATUS 2'd2

// Threshold values after reset, in bytes
`define BUF_AF_RESET 7'd60
`define BUF_AE_RESET 7'd4

`endif

/* buf_pkg.sv */
`include "buf_config.svh"

package buf_pkg;

	// One byte as seen on the read port
	typedef logic [`BUF_BYTE_W-1:0] buf_byte_t;

	// A stored word, written whole and read one lane at a time
	// Lane 0 is the lowest byte and leaves the FIFO first
	typedef union packed {
		logic [`BUF_WORD_W-1:0] word;
		buf_byte_t [`BUF_LANES-1:0] lanes;
	} buf_word_u;

	// FIFO fill state, level counted in bytes
	typedef struct packed {
		logic [`BUF_LEVEL_W-1:0] level;
		logic full;
		logic empty;
	} buf_status_t;

	// Settings from the register block
	typedef struct packed {
		logic flush;
		logic [`BUF_LEVEL_W-1:0] af_level;
		logic [`BUF_LEVEL_W-1:0] ae_level;
	} buf_cfg_t;

	// STATUS register layout
	typedef struct packed {
		logic [13:0] rsvd_hi;
		logic empty;
		logic full;
		logic [5:0] rsvd_mid;
		logic underflow;
		logic overflow;
		logic rsvd_lo;
		logic [`BUF_LEVEL_W-1:0] level;
	} buf_status_reg_t;

endpackage

/* asym_dp_ram.sv */
`timescale 1ns/1ns
`include "buf_config.svh"

module asym_dp_ram
	import buf_pkg::*;
(
	input  logic                     clk,
	input  logic                     wr_en,
	input  logic [`BUF_W_ADDR_W-1:0] wr_addr,
	input  buf_word_u                wr_data,
	input  logic                     rd_en,
	input  logic [`BUF_R_ADDR_W-1:0] rd_addr,
	output buf_byte_t                rd_data
);

	// Low read address bits pick the lane inside a word
	localparam int LANE_SEL_W = `BUF_R_ADDR_W - `BUF_W_ADDR_W;
	localparam int WORDS = 2 ** `BUF_W_ADDR_W;

	buf_word_u mem [0:WORDS-1];

	logic [`BUF_W_ADDR_W-1:0] rd_word;
	logic [LANE_SEL_W-1:0] rd_lane;

	assign rd_word = rd_addr[`BUF_R_ADDR_W-1:LANE_SEL_W];
	assign rd_lane = rd_addr[LANE_SEL_W-1:0];

	// Write port stores the full word
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read port returns one byte lane, registered
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data <= mem[rd_word].lanes[rd_lane];
		end
	end

endmodule

/* asym_sync_fifo.sv */
`timescale 1ns/1ns
`include "buf_config.svh"

module asym_sync_fifo
	import buf_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  buf_cfg_t    cfg,
	input  logic        wr_en,
	input  buf_word_u   wr_data,
	input  logic        rd_en,
	output buf_byte_t   rd_data,
	output logic        rd_valid,
	output buf_status_t status,
	output logic        wr_drop,
	output logic        rd_drop
);

	// Full once less than one word of space is left
	localparam logic [`BUF_LEVEL_W-1:0] FULL_LIMIT =
		`BUF_LEVEL_W'(`BUF_DEPTH_BYTES - `BUF_LANES);
	localparam logic [`BUF_LEVEL_W-1:0] WORD_INC = `BUF_LEVEL_W'(`BUF_LANES);
	localparam logic [`BUF_LEVEL_W-1:0] BYTE_DEC = `BUF_LEVEL_W'(1);

	logic [`BUF_W_ADDR_W-1:0] wr_ptr;
	logic [`BUF_R_ADDR_W-1:0] rd_ptr;
	logic [`BUF_LEVEL_W-1:0] level;
	logic wr_acc;
	logic rd_acc;

	// Flags straight from the byte count
	assign status.level = level;
	assign status.full = (level > FULL_LIMIT);
	assign status.empty = (level == '0);

	// Qualified strobes, a flush cycle takes nothing in or out
	assign wr_acc = wr_en & ~status.full & ~cfg.flush;
	assign rd_acc = rd_en & ~status.empty & ~cfg.flush;

	// Errors reported to the register block
	assign wr_drop = wr_en & status.full;
	assign rd_drop = rd_en & status.empty;

	// Word write pointer
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
		end
		else if (cfg.flush)
		begin
			wr_ptr <= '0;
		end
		else if (wr_acc)
		begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Byte read pointer, wraps together with the word pointer
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rd_ptr <= '0;
		end
		else if (cfg.flush)
		begin
			rd_ptr <= '0;
		end
		else if (rd_acc)
		begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Occupancy in bytes
	// A word in and a byte out in one cycle nets plus three
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			level <= '0;
		end
		else if (cfg.flush)
		begin
			level <= '0;
		end
		else
		begin
			case ({wr_acc, rd_acc})
				2'b10: level <= level + WORD_INC;
				2'b01: level <= level - BYTE_DEC;
				2'b11: level <= level + WORD_INC - BYTE_DEC;
				default: level <= level;
			endcase
		end
	end

	// Read data shows up one cycle after the accepting edge
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_acc;
		end
	end

	asym_dp_ram u_ram (
		.clk     (clk),
		.wr_en   (wr_acc),
		.wr_addr (wr_ptr),
		.wr_data (wr_data),
		.rd_en   (rd_acc),
		.rd_addr (rd_ptr),
		.rd_data (rd_data)
	);

endmodule

/* buf_ctrl_regs.sv */
`timescale 1ns/1ns
`include "buf_config.svh"

module buf_ctrl_regs
	import buf_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       reg_wr,
	input  logic [`BUF_REG_ADDR_W-1:0] reg_addr,
	input  logic [`BUF_REG_DATA_W-1:0] reg_wdata,
	output logic [`BUF_REG_DATA_W-1:0] reg_rdata,
	input  buf_status_t                status,
	input  logic                       wr_drop,
	input  logic                       rd_drop,
	output buf_cfg_t                   cfg,
	output logic                       almost_full,
	output logic                       almost_empty
);

	// THRESH field positions
	localparam int AF_LSB = 0;
	localparam int AE_LSB = 8;
	// STATUS write-one-to-clear bits
	localparam int OVF_BIT = 8;
	localparam int UNF_BIT = 9;

	buf_cfg_t cfg_q;
	logic overflow;
	logic underflow;
	logic wr_ctrl;
	logic wr_thresh;
	logic wr_status;
	buf_status_reg_t status_word;
	logic [`BUF_REG_DATA_W-1:0] thresh_word;

	assign wr_ctrl = reg_wr && (reg_addr == `BUF_REG_CTRL);
	assign wr_thresh = reg_wr && (reg_addr == `BUF_REG_THRESH);
	assign wr_status = reg_wr && (reg_addr == `BUF_REG_STATUS);

	// Flush pulse lasts one cycle and the thresholds hold until rewritten
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cfg_q.flush <= 1'b0;
			cfg_q.af_level <= `BUF_AF_RESET;
			cfg_q.ae_level <= `BUF_AE_RESET;
		end
		else
		begin
			cfg_q.flush <= wr_ctrl & reg_wdata[0];
			if (wr_thresh)
			begin
				cfg_q.af_level <= reg_wdata[AF_LSB +: `BUF_LEVEL_W];
				cfg_q.ae_level <= reg_wdata[AE_LSB +: `BUF_LEVEL_W];
			end
		end
	end

	assign cfg = cfg_q;

	// Sticky error flags
	// a new drop wins over a clear in the same cycle
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			overflow <= 1'b0;
			underflow <= 1'b0;
		end
		else
		begin
			if (wr_drop)
				overflow <= 1'b1;
			else if (wr_status && reg_wdata[OVF_BIT])
				overflow <= 1'b0;

			if (rd_drop)
				underflow <= 1'b1;
			else if (wr_status && reg_wdata[UNF_BIT])
				underflow <= 1'b0;
		end
	end

	// Alarms track the live level
	assign almost_full = (status.level >= cfg_q.af_level);
	assign almost_empty = (status.level <= cfg_q.ae_level);

	always_comb
	begin
		status_word = '0;
		status_word.level = status.level;
		status_word.full = status.full;
		status_word.empty = status.empty;
		status_word.overflow = overflow;
		status_word.underflow = underflow;
	end

	always_comb
	begin
		thresh_word = '0;
		thresh_word[AF_LSB +: `BUF_LEVEL_W] = cfg_q.af_level;
		thresh_word[AE_LSB +: `BUF_LEVEL_W] = cfg_q.ae_level;
	end

	// Read mux, no latency
	always_comb
	begin
		case (reg_addr)
			`BUF_REG_CTRL: reg_rdata = `BUF_REG_DATA_W'(cfg_q.flush);
			`BUF_REG_THRESH: reg_rdata = thresh_word;
			`BUF_REG_STATUS: reg_rdata = status_word;
			default: reg_rdata = '0;
		endcase
	end

endmodule

/* word_to_byte_buffer.sv */
`timescale 1ns/1ns
`include "buf_config.svh"

module word_to_byte_buffer
	import buf_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,

	// Word producer
	input  logic                       wr_en,
	input  buf_word_u                  wr_data,

	// Byte consumer
	input  logic                       rd_en,
	output buf_byte_t                  rd_data,
	output logic                       rd_valid,
	output logic                       full,
	output logic                       empty,

	// Register access
	input  logic                       reg_wr,
	input  logic [`BUF_REG_ADDR_W-1:0] reg_addr,
	input  logic [`BUF_REG_DATA_W-1:0] reg_wdata,
	output logic [`BUF_REG_DATA_W-1:0] reg_rdata,

	// Level alarms
	output logic                       almost_full,
	output logic                       almost_empty
);

	buf_status_t status;
	buf_cfg_t cfg;
	logic wr_drop;
	logic rd_drop;

	assign full = status.full;
	assign empty = status.empty;

	asym_sync_fifo u_fifo (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.status   (status),
		.wr_drop  (wr_drop),
		.rd_drop  (rd_drop)
	);

	// Control and status registers next to the FIFO
	buf_ctrl_regs u_regs (
		.clk          (clk),
		.rst          (rst),
		.reg_wr       (reg_wr),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_rdata    (reg_rdata),
		.status       (status),
		.wr_drop      (wr_drop),
		.rd_drop      (rd_drop),
		.cfg          (cfg),
		.almost_full  (almost_full),
		.almost_empty (almost_empty)
	);

endmodule

/* tb_word_to_byte_buffer.sv */
`timescale 1ns/1ns
`include "buf_config.svh"

module tb_word_to_byte_buffer
	import buf_pkg::*;
();

	typedef enum int {
		OP_IDLE,
		OP_WRITE,
		OP_READ,
		OP_READ_EMPTY,
		OP_WR_RD,
		OP_REG_WR,
		OP_STATUS,
		OP_FLAGS
	} op_e;

	localparam int MAX_ENTRIES = 256;

	logic clk = 1'b0;
	logic rst;
	logic wr_en;
	buf_word_u wr_data;
	logic rd_en;
	buf_byte_t rd_data;
	logic rd_valid;
	logic full;
	logic empty;
	logic reg_wr;
	logic [`BUF_REG_ADDR_W-1:0] reg_addr;
	logic [`BUF_REG_DATA_W-1:0] reg_wdata;
	logic [`BUF_REG_DATA_W-1:0] reg_rdata;
	logic almost_full;
	logic almost_empty;

	// Stimulus table
	op_e tab_op [0:MAX_ENTRIES-1];
	logic [`BUF_REG_ADDR_W-1:0] tab_addr [0:MAX_ENTRIES-1];
	logic [31:0] tab_data [0:MAX_ENTRIES-1];
	logic [31:0] tab_exp [0:MAX_ENTRIES-1];
	string tab_name [0:MAX_ENTRIES-1];
	int n_entries;

	// Bytes still due out of the FIFO in arrival order
	buf_byte_t exp_bytes [$];
	integer seed;
	int cycles = 0;
	int cycle_limit;

	word_to_byte_buffer DUT (
		.clk          (clk),
		.rst          (rst),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.rd_en        (rd_en),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid),
		.full         (full),
		.empty        (empty),
		.reg_wr       (reg_wr),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_rdata    (reg_rdata),
		.almost_full  (almost_full),
		.almost_empty (almost_empty)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
			stop_with_failure("Timeout, the test table did not finish in time");
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_byte(input string name, input buf_byte_t exp);
		if (rd_valid !== 1'b1)
			stop_with_failure({"rd_valid was not high one cycle after the read in ", name});
		if (rd_data !== exp)
			stop_with_failure($sformatf("MISMATCH %s expected %02h actual %02h",
				name, exp, rd_data));
	endtask

	task automatic check_status(input string name, input buf_status_reg_t exp);
		if (reg_rdata !== exp)
			stop_with_failure($sformatf("MISMATCH %s expected %08h actual %08h",
				name, exp, reg_rdata));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	task automatic add_entry(input op_e op, input logic [1:0] addr, input logic [31:0] data,
		input logic [31:0] exp, input string name);
		tab_op[n_entries] = op;
		tab_addr[n_entries] = addr;
		tab_data[n_entries] = data;
		tab_exp[n_entries] = exp;
		tab_name[n_entries] = name;
		n_entries++;
	endtask

	// Lane 0 is the low byte and leaves first
	task automatic push_lanes(input logic [31:0] w);
		for (int k = 0; k < 4; k++)
			exp_bytes.push_back(w[8*k +: 8]);
	endtask

	task automatic add_write(input string name, input bit stored);
		logic [31:0] w;
		w = $random(seed);
		add_entry(OP_WRITE, '0, w, '0, name);
		if (stored)
			push_lanes(w);
	endtask

	task automatic add_reads(input string name, input int count);
		for (int k = 0; k < count; k++)
			add_entry(OP_READ, '0, '0, exp_bytes.pop_front(), name);
	endtask

	task automatic add_wr_rd(input string name);
		logic [31:0] w;
		buf_byte_t b;
		w = $random(seed);
		b = exp_bytes.pop_front();
		push_lanes(w);
		add_entry(OP_WR_RD, '0, w, b, name);
	endtask

	task automatic add_status(input string name, input int level, input bit f, input bit e,
		input bit ovf, input bit unf);
		buf_status_reg_t s;
		s = '0;
		s.level = `BUF_LEVEL_W'(level);
		s.full = f;
		s.empty = e;
		s.overflow = ovf;
		s.underflow = unf;
		add_entry(OP_STATUS, `BUF_REG_STATUS, '0, s, name);
	endtask

	task automatic add_flags(input string name, input bit af, input bit ae);
		add_entry(OP_FLAGS, '0, '0, {30'd0, af, ae}, name);
	endtask

	task automatic build_table();
		add_status("reset_status", 0, 0, 1, 0, 0);
		add_flags("reset_alarms", 0, 1);
		// Three words out as twelve bytes
		for (int k = 0; k < 3; k++)
			add_write("order_write", 1);
		add_status("order_level", 12, 0, 0, 0, 0);
		add_reads("order_read", 12);
		add_status("order_drained", 0, 0, 1, 0, 0);
		// Read from an empty FIFO
		add_entry(OP_READ_EMPTY, '0, '0, '0, "underflow_read");
		add_status("underflow_set", 0, 0, 1, 0, 1);
		add_entry(OP_REG_WR, `BUF_REG_STATUS, 32'h0000_0200, '0, "underflow_clear");
		add_status("underflow_cleared", 0, 0, 1, 0, 0);
		// Fill up and then one write too many
		for (int k = 0; k < 16; k++)
			add_write("fill_write", 1);
		add_status("fill_full", 64, 1, 0, 0, 0);
		add_flags("fill_alarms", 1, 0);
		add_write("overflow_write", 0);
		add_status("overflow_set", 64, 1, 0, 1, 0);
		add_entry(OP_REG_WR, `BUF_REG_STATUS, 32'h0000_0100, '0, "overflow_clear");
		add_status("overflow_cleared", 64, 1, 0, 0, 0);
		add_reads("fill_read", 64);
		add_status("fill_drained", 0, 0, 1, 0, 0);
		// Word in and byte out in one cycle
		add_write("both_first", 1);
		add_wr_rd("both_same_cycle");
		add_status("both_level", 7, 0, 0, 0, 0);
		add_reads("both_read", 7);
		add_status("both_drained", 0, 0, 1, 0, 0);
		// Thresholds of 8 and 2 bytes
		add_entry(OP_REG_WR, `BUF_REG_THRESH, 32'h0000_0208, '0, "thresh_write");
		add_flags("thresh_level0", 0, 1);
		add_write("thresh_fill", 1);
		add_flags("thresh_level4", 0, 0);
		add_write("thresh_fill", 1);
		add_flags("thresh_level8", 1, 0);
		add_reads("thresh_read", 1);
		add_flags("thresh_level7", 0, 0);
		add_reads("thresh_read", 4);
		add_flags("thresh_level3", 0, 0);
		add_reads("thresh_read", 1);
		add_flags("thresh_level2", 0, 1);
		add_reads("thresh_read", 1);
		add_flags("thresh_level1", 0, 1);
		// Flush of a partial fill
		add_write("flush_fill", 1);
		add_write("flush_fill", 1);
		add_status("flush_before", 9, 0, 0, 0, 0);
		add_entry(OP_REG_WR, `BUF_REG_CTRL, 32'h0000_0001, '0, "flush_write");
		add_entry(OP_IDLE, '0, '0, '0, "flush_wait");
		add_status("flush_after", 0, 0, 1, 0, 0);
		add_flags("flush_alarms", 0, 1);
		exp_bytes.delete();
		add_write("flush_next_write", 1);
		add_status("flush_next_level", 4, 0, 0, 0, 0);
		add_reads("flush_next_read", 4);
		add_status("flush_drained", 0, 0, 1, 0, 0);
	endtask

	// One table entry per clock with inputs changing 2 ns after the edge
	task automatic run_entry(input int i);
		buf_status_reg_t exp_status;
		exp_status = tab_exp[i];
		case (tab_op[i])
			OP_WRITE:
			begin
				wr_en = 1'b1;
				wr_data = tab_data[i];
			end
			OP_READ, OP_READ_EMPTY: rd_en = 1'b1;
			OP_WR_RD:
			begin
				wr_en = 1'b1;
				wr_data = tab_data[i];
				rd_en = 1'b1;
			end
			OP_REG_WR:
			begin
				reg_wr = 1'b1;
				reg_addr = tab_addr[i];
				reg_wdata = tab_data[i];
			end
			OP_STATUS: reg_addr = tab_addr[i];
			default: ;
		endcase
		#1;
		if (tab_op[i] == OP_STATUS)
		begin
			check_status(tab_name[i], exp_status);
			check_flag({tab_name[i], " full"}, exp_status.full, full);
			check_flag({tab_name[i], " empty"}, exp_status.empty, empty);
		end
		if (tab_op[i] == OP_FLAGS)
		begin
			check_flag({tab_name[i], " almost_full"}, tab_exp[i][1], almost_full);
			check_flag({tab_name[i], " almost_empty"}, tab_exp[i][0], almost_empty);
		end
		@(posedge clk);
		#2;
		wr_en = 1'b0;
		rd_en = 1'b0;
		reg_wr = 1'b0;
		if (tab_op[i] == OP_READ || tab_op[i] == OP_WR_RD)
			check_byte(tab_name[i], tab_exp[i][7:0]);
		if (tab_op[i] == OP_READ_EMPTY)
			check_flag({tab_name[i], " rd_valid"}, 1'b0, rd_valid);
	endtask

	initial
	begin
		rst = 1'b1;
		wr_en = 1'b0;
		wr_data = '0;
		rd_en = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		seed = 72;
		n_entries = 0;
		build_table();
		cycle_limit = 16 + 4 * n_entries + 50;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < n_entries; i++)
			run_entry(i);
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+.
buf_pkg.sv
asym_dp_ram.sv
asym_sync_fifo.sv
buf_ctrl_regs.sv
word_to_byte_buffer.sv
tb_word_to_byte_buffer.sv
